//--- build.f
+incdir+design
design/rgbw_reg_pkg.sv
design/rgbw_pwm_pkg.sv
design/spi_byte_rx.sv
design/rgbw_frame_decoder.sv
design/rgbw_pwm_engine.sv
design/rgbw_readback.sv
design/rgbw_controller_top.sv
verification/rgbw_controller_sva.sv
verification/rgbw_controller_tb.sv

//--- design/rgbw_config.svh
// rgbw controller build-time configuration
// PWM prescale, input synchroniser depth and register count

`ifndef RGBW_CONFIG_SVH
`define RGBW_CONFIG_SVH

// clk cycles per PWM counter step
// one full PWM period is 256 times this
`define RGBW_PWM_PRESCALE 4

// flip-flop depth of the SPI pin synchronisers
// must be 2 or more
`define RGBW_SYNC_STAGES 2

// writable registers in the bank
// indices 0..6, select 7 aliases white on readback
`define RGBW_NUM_REGS 7

`endif

//--- design/rgbw_controller_top.sv
// rgbw LED controller top level
// SPI receiver, frame decoder, PWM engine and readback wired together

`timescale 1ns/100ps
`default_nettype none

module rgbw_controller_top import rgbw_reg_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       sck,
    input  logic       cs,
    input  logic       mosi,
    input  reg_idx_t   readback_sel,
    output logic [3:0] pwm,
    output reg_val_t   rb_data
);

    // receiver to decoder
    logic      frame_start;
    logic      byte_valid;
    spi_byte_u rx_byte;

    // register bank
    reg_val_t  reg_intensity;
    reg_val_t  reg_red;
    reg_val_t  reg_green;
    reg_val_t  reg_blue;
    reg_val_t  reg_color_idx;
    reg_val_t  reg_mode;
    reg_val_t  reg_white;

    spi_byte_rx u_spi_rx (
        .clk         (clk),
        .reset       (reset),
        .sck         (sck),
        .cs          (cs),
        .mosi        (mosi),
        .frame_start (frame_start),
        .byte_valid  (byte_valid),
        .rx_byte     (rx_byte)
    );

    rgbw_frame_decoder u_decoder (
        .clk           (clk),
        .reset         (reset),
        .frame_start   (frame_start),
        .byte_valid    (byte_valid),
        .rx_byte       (rx_byte),
        .reg_intensity (reg_intensity),
        .reg_red       (reg_red),
        .reg_green     (reg_green),
        .reg_blue      (reg_blue),
        .reg_color_idx (reg_color_idx),
        .reg_mode      (reg_mode),
        .reg_white     (reg_white)
    );

    // colour index is stored and read back only
    rgbw_pwm_engine u_pwm (
        .clk       (clk),
        .reset     (reset),
        .intensity (reg_intensity),
        .red       (reg_red),
        .green     (reg_green),
        .blue      (reg_blue),
        .white     (reg_white),
        .mode      (reg_mode),
        .pwm       (pwm)
    );

    rgbw_readback u_readback (
        .clk           (clk),
        .reset         (reset),
        .readback_sel  (readback_sel),
        .reg_intensity (reg_intensity),
        .reg_red       (reg_red),
        .reg_green     (reg_green),
        .reg_blue      (reg_blue),
        .reg_color_idx (reg_color_idx),
        .reg_mode      (reg_mode),
        .reg_white     (reg_white),
        .rb_data       (rb_data)
    );

endmodule

`default_nettype wire

//--- design/rgbw_frame_decoder.sv
// rgbw frame decoder
// splits each SPI frame into header and data bytes and owns the register bank

`timescale 1ns/100ps
`default_nettype none

`include "rgbw_config.svh"

module rgbw_frame_decoder import rgbw_reg_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      frame_start,
    input  logic      byte_valid,
    input  spi_byte_u rx_byte,
    output reg_val_t  reg_intensity,
    output reg_val_t  reg_red,
    output reg_val_t  reg_green,
    output reg_val_t  reg_blue,
    output reg_val_t  reg_color_idx,
    output reg_val_t  reg_mode,
    output reg_val_t  reg_white
);

    localparam int num_regs = `RGBW_NUM_REGS;
    localparam reg_idx_t last_idx = reg_idx_t'(num_regs - 1);

    // next byte in the frame is the header
    logic     expect_hdr;
    // frame is writing and the index has not run off the bank
    logic     wr_active;
    reg_idx_t wr_idx;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            expect_hdr    <= 1'b0;
            wr_active     <= 1'b0;
            wr_idx        <= '0;
            reg_intensity <= '0;
            reg_red       <= '0;
            reg_green     <= '0;
            reg_blue      <= '0;
            reg_color_idx <= '0;
            reg_mode      <= '0;
            reg_white     <= '0;
        end
        else if (frame_start)
        begin
            expect_hdr <= 1'b1;
            wr_active  <= 1'b0;
        end
        else if (byte_valid)
        begin
            if (expect_hdr)
            begin
                // header view of the byte
                expect_hdr <= 1'b0;
                wr_active  <= rx_byte.hdr.write_flag;
                wr_idx     <= rx_byte.hdr.start_idx;
            end
            else if (wr_active)
            begin
                // data view, one register per byte
                case (wr_idx)
                    idx_intensity: reg_intensity <= rx_byte.data;
                    idx_red:       reg_red       <= rx_byte.data;
                    idx_green:     reg_green     <= rx_byte.data;
                    idx_blue:      reg_blue      <= rx_byte.data;
                    idx_color_idx: reg_color_idx <= rx_byte.data;
                    idx_mode:      reg_mode      <= rx_byte.data;
                    idx_white:     reg_white     <= rx_byte.data;
                    // start index 7 writes nothing
                    default: ;
                endcase
                // stop at the end of the bank instead of wrapping to 0
                if (wr_idx >= last_idx)
                    wr_active <= 1'b0;
                else
                    wr_idx <= wr_idx + 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/rgbw_pwm_engine.sv
// rgbw PWM engine
// scales each colour by intensity and drives four PWM outputs off one counter

`timescale 1ns/100ps
`default_nettype none

`include "rgbw_config.svh"

module rgbw_pwm_engine import rgbw_reg_pkg::*, rgbw_pwm_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  reg_val_t             intensity,
    input  reg_val_t             red,
    input  reg_val_t             green,
    input  reg_val_t             blue,
    input  reg_val_t             white,
    input  reg_val_t             mode,
    output logic [num_chans-1:0] pwm
);

    localparam int prescale = `RGBW_PWM_PRESCALE;
    localparam int pre_w    = (prescale > 1) ? $clog2(prescale) : 1;

    reg_val_t   colour [num_chans];
    duty_t      duty_q [num_chans];
    logic [pre_w-1:0] pre_cnt;
    logic       tick;
    pwm_cnt_t   cnt;
    logic [num_chans-1:0] pwm_q;

    // colour * (intensity + 1) / 256, truncated
    // intensity 255 passes the colour unchanged
    function automatic duty_t scale(input reg_val_t c, input reg_val_t i);
        logic [15:0] prod;
        prod = 16'(c) * (16'(i) + 16'd1);
        return prod[15:8];
    endfunction

    assign colour[chan_red]   = red;
    assign colour[chan_green] = green;
    assign colour[chan_blue]  = blue;
    assign colour[chan_white] = white;

    // duties follow the registers one cycle later
    always_ff @(posedge clk)
    begin
        for (int ch = 0; ch < num_chans; ch++)
            duty_q[ch] <= scale(colour[ch], intensity);
    end

    // prescale tick and shared period counter
    assign tick = (pre_cnt == pre_w'(prescale - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pre_cnt <= '0;
            cnt     <= '0;
        end
        else if (tick)
        begin
            pre_cnt <= '0;
            // natural wrap at 256
            cnt     <= cnt + 8'd1;
        end
        else
            pre_cnt <= pre_cnt + pre_w'(1);
    end

    // high while the counter is below the duty
    always_ff @(posedge clk)
    begin
        if (reset)
            pwm_q <= '0;
        else
            for (int ch = 0; ch < num_chans; ch++)
                pwm_q[ch] <= (cnt < duty_q[ch]);
    end

    // mode bit 0 is the global enable, applied without delay
    assign pwm = pwm_q & {num_chans{mode[0]}};

endmodule

`default_nettype wire

//--- design/rgbw_pwm_pkg.sv
// rgbw PWM package
// duty and counter types plus the output channel enumeration

`default_nettype none

package rgbw_pwm_pkg;

    // on-time per period in counter steps
    typedef logic [7:0] duty_t;

    // free-running period counter, wraps at 256
    typedef logic [7:0] pwm_cnt_t;

    // bit position of each colour on the pwm port
    typedef enum logic [1:0] {
        chan_red   = 2'd0,
        chan_green = 2'd1,
        chan_blue  = 2'd2,
        chan_white = 2'd3
    } pwm_chan_e;

    localparam int num_chans = 4;

endpackage

`default_nettype wire

//--- design/rgbw_readback.sv
// rgbw readback stage
// registered mux of the register bank onto the host readback port

`timescale 1ns/100ps
`default_nettype none

`include "rgbw_config.svh"

module rgbw_readback import rgbw_reg_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t readback_sel,
    input  reg_val_t reg_intensity,
    input  reg_val_t reg_red,
    input  reg_val_t reg_green,
    input  reg_val_t reg_blue,
    input  reg_val_t reg_color_idx,
    input  reg_val_t reg_mode,
    input  reg_val_t reg_white,
    output reg_val_t rb_data
);

    localparam int num_regs = `RGBW_NUM_REGS;

    // bank gathered into an array in register-map order
    reg_val_t bank [num_regs];

    assign bank[idx_intensity] = reg_intensity;
    assign bank[idx_red]       = reg_red;
    assign bank[idx_green]     = reg_green;
    assign bank[idx_blue]      = reg_blue;
    assign bank[idx_color_idx] = reg_color_idx;
    assign bank[idx_mode]      = reg_mode;
    assign bank[idx_white]     = reg_white;

    always_ff @(posedge clk)
    begin
        if (reset)
            rb_data <= '0;
        else if (readback_sel < reg_idx_t'(num_regs))
            rb_data <= bank[readback_sel];
        else
            // out-of-range select shows white
            rb_data <= reg_white;
    end

endmodule

`default_nettype wire

//--- design/rgbw_reg_pkg.sv
// rgbw register map package
// register index and value types, SPI frame header layout and byte union

`default_nettype none

package rgbw_reg_pkg;

    // register index, 3 bits covers the seven registers plus one alias
    typedef logic [2:0] reg_idx_t;

    // register contents
    typedef logic [7:0] reg_val_t;

    // register map
    localparam reg_idx_t idx_intensity = 3'd0;
    localparam reg_idx_t idx_red       = 3'd1;
    localparam reg_idx_t idx_green     = 3'd2;
    localparam reg_idx_t idx_blue      = 3'd3;
    localparam reg_idx_t idx_color_idx = 3'd4;
    localparam reg_idx_t idx_mode      = 3'd5;
    localparam reg_idx_t idx_white     = 3'd6;

    // first byte of a chip-select frame
    typedef struct packed {
        // 1 = following bytes write the bank
        logic       write_flag;
        logic [3:0] reserved;
        // first register written
        reg_idx_t   start_idx;
    } frame_hdr_t;

    // one received SPI byte, header or data depending on frame position
    typedef union packed {
        frame_hdr_t hdr;
        reg_val_t   data;
    } spi_byte_u;

endpackage

`default_nettype wire

//--- design/spi_byte_rx.sv
// SPI mode-0 slave byte receiver
// synchronises the pins into clk, shifts bytes MSB first, flags frame start

`timescale 1ns/100ps
`default_nettype none

`include "rgbw_config.svh"

module spi_byte_rx import rgbw_reg_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      sck,
    input  logic      cs,
    input  logic      mosi,
    output logic      frame_start,
    output logic      byte_valid,
    output spi_byte_u rx_byte
);

    localparam int sync_stages = `RGBW_SYNC_STAGES;

    // synchroniser chains, oldest sample at the top bit
    logic [sync_stages-1:0] sck_sync;
    logic [sync_stages-1:0] cs_sync;
    logic [sync_stages-1:0] mosi_sync;

    logic     sck_s;
    logic     cs_s;
    logic     mosi_s;
    // previous synchronised levels for edge detection
    logic     sck_d;
    logic     cs_d;
    logic     sck_rise;
    logic     cs_fall;
    logic [2:0] bit_cnt;
    reg_val_t shift_reg;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sck_sync  <= '0;
            // cs idles high so no frame start comes out of reset
            cs_sync   <= '1;
            mosi_sync <= '0;
            sck_d     <= 1'b0;
            cs_d      <= 1'b1;
        end
        else
        begin
            sck_sync  <= {sck_sync[sync_stages-2:0], sck};
            cs_sync   <= {cs_sync[sync_stages-2:0], cs};
            mosi_sync <= {mosi_sync[sync_stages-2:0], mosi};
            sck_d     <= sck_s;
            cs_d      <= cs_s;
        end
    end

    assign sck_s    = sck_sync[sync_stages-1];
    assign cs_s     = cs_sync[sync_stages-1];
    // mosi goes through the same depth so it lines up with sck
    assign mosi_s   = mosi_sync[sync_stages-1];
    assign sck_rise = sck_s & ~sck_d;
    assign cs_fall  = ~cs_s & cs_d;

    // bit counter and strobes
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            bit_cnt     <= '0;
            byte_valid  <= 1'b0;
            frame_start <= 1'b0;
        end
        else
        begin
            frame_start <= cs_fall;
            byte_valid  <= 1'b0;
            if (cs_s)
                // deselected, any partial byte is dropped
                bit_cnt <= '0;
            else if (sck_rise)
            begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7)
                    byte_valid <= 1'b1;
            end
        end
    end

    // shift register, MSB arrives first
    always_ff @(posedge clk)
    begin
        if (!cs_s && sck_rise)
            shift_reg <= {shift_reg[6:0], mosi_s};
    end

    // stable until the next sck edge, at least 8 clk away
    assign rx_byte.data = shift_reg;

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the rgbw controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f build.f \
    --top-module rgbw_controller_tb \
    -Mdir obj_dir \
    -o rgbw_sim

# assertion errors must not stop the run before the summary
./obj_dir/rgbw_sim +verilator+error+limit+1000 | tee sim.log

# the log decides pass or fail
grep -q "SIMULATION PASSED" sim.log
echo "run.sh: simulation run complete"

//--- verification/rgbw_controller_sva.sv
// rgbw controller assertions
// strobe widths, PWM enable gating and readback reset value

`timescale 1ns/100ps
`default_nettype none

module rgbw_controller_sva import rgbw_reg_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       frame_start,
    input logic       byte_valid,
    input reg_val_t   reg_mode,
    input logic [3:0] pwm,
    input reg_val_t   rb_data
);

    // number of failed assertions so far
    int unsigned fail_count = 0;

    // receiver strobes are single-cycle pulses
    a_frame_start_pulse: assert property (@(posedge clk) disable iff (reset)
        frame_start |=> !frame_start)
    else
    begin
        $error("frame_start high for more than one cycle");
        fail_count++;
    end

    a_byte_valid_pulse: assert property (@(posedge clk) disable iff (reset)
        byte_valid |=> !byte_valid)
    else
    begin
        $error("byte_valid high for more than one cycle");
        fail_count++;
    end

    // mode bit 0 gates every channel
    a_pwm_disabled: assert property (@(posedge clk) disable iff (reset)
        !reg_mode[0] |-> (pwm == 4'h0))
    else
    begin
        $error("pwm = 0x%01h while mode bit 0 is clear", pwm);
        fail_count++;
    end

    // readback register clears on reset
    a_rb_reset: assert property (@(posedge clk)
        reset |=> (rb_data == 8'h00))
    else
    begin
        $error("rb_data = 0x%02h after reset", rb_data);
        fail_count++;
    end

endmodule

bind rgbw_controller_top rgbw_controller_sva u_sva (
    .clk         (clk),
    .reset       (reset),
    .frame_start (frame_start),
    .byte_valid  (byte_valid),
    .reg_mode    (reg_mode),
    .pwm         (pwm),
    .rb_data     (rb_data)
);

`default_nettype wire

//--- verification/rgbw_controller_tb.sv
// rgbw controller testbench
// sends SPI frames, checks readback against a register model and measures PWM duty

`timescale 1ns/100ps
`default_nettype none

`include "rgbw_config.svh"

module rgbw_controller_tb import rgbw_reg_pkg::*, rgbw_pwm_pkg::*; ();

    // one full PWM period in clk cycles
    localparam int window       = 256 * `RGBW_PWM_PRESCALE;
    localparam int byte_timeout = 64;

    logic       clk = 1'b0;
    logic       reset;
    logic       sck;
    logic       cs;
    logic       mosi;
    reg_idx_t   readback_sel;
    logic [3:0] pwm;
    reg_val_t   rb_data;

    // bytes of the next frame with the header first
    reg_val_t frame_q [$];
    // expected register bank
    reg_val_t model_regs [`RGBW_NUM_REGS];

    int byte_count   = 0;
    int error_count  = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    rgbw_controller_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .sck          (sck),
        .cs           (cs),
        .mosi         (mosi),
        .readback_sel (readback_sel),
        .pwm          (pwm),
        .rb_data      (rb_data)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    // count received bytes at the falling edge
    always @(negedge clk)
    begin
        if (u_dut.byte_valid === 1'b1)
            byte_count <= byte_count + 1;
    end

    function automatic reg_val_t rand_byte();
        return reg_val_t'($urandom);
    endfunction

    function automatic reg_val_t make_hdr(input logic wr, input reg_idx_t start);
        frame_hdr_t hdr;
        hdr.write_flag = wr;
        hdr.reserved   = 4'h0;
        hdr.start_idx  = start;
        return reg_val_t'(hdr);
    endfunction

    // colour times intensity+1 over 256 with truncation
    function automatic duty_t duty_for(input reg_val_t c, input reg_val_t i);
        int prod;
        prod = int'(c) * (int'(i) + 1);
        return duty_t'(prod / 256);
    endfunction

    function automatic reg_idx_t chan_reg(input pwm_chan_e ch);
        case (ch)
            chan_red:   return idx_red;
            chan_green: return idx_green;
            chan_blue:  return idx_blue;
            default:    return idx_white;
        endcase
    endfunction

    // select 7 aliases white
    function automatic reg_val_t expected_rb(input reg_idx_t sel);
        if (int'(sel) < `RGBW_NUM_REGS)
            return model_regs[sel];
        else
            return model_regs[idx_white];
    endfunction

    // frame rule applied to the first n complete bytes
    task automatic model_frame(input int n);
        frame_hdr_t hdr;
        int idx;
        int i;
        if (n > 0)
        begin
            hdr = frame_hdr_t'(frame_q[0]);
            idx = int'(hdr.start_idx);
            if (hdr.write_flag)
            begin
                for (i = 1; i < n; i++)
                begin
                    // past the last register the bytes are dropped
                    if (idx < `RGBW_NUM_REGS)
                    begin
                        model_regs[idx] = frame_q[i];
                        idx++;
                    end
                end
            end
        end
    endtask

    // bit-bang frame_q and cut the last byte short when cut_bits is nonzero
    task automatic send_frame(input int cut_bits);
        int full_bytes;
        int target;
        int waited;
        int nbits;
        int i;
        int k;
        reg_val_t b;
        full_bytes = (cut_bits > 0) ? frame_q.size() - 1 : frame_q.size();
        target     = byte_count + full_bytes;
        @(posedge clk);
        cs <= 1'b0;
        repeat (4) @(posedge clk);
        for (i = 0; i < frame_q.size(); i++)
        begin
            b     = frame_q[i];
            nbits = (cut_bits > 0 && i == frame_q.size() - 1) ? cut_bits : 8;
            for (k = 0; k < nbits; k++)
            begin
                // mode 0 so data changes while sck is low
                // 8 clk per bit
                mosi <= b[7 - k];
                repeat (4) @(posedge clk);
                sck <= 1'b1;
                repeat (4) @(posedge clk);
                sck <= 1'b0;
            end
        end
        repeat (4) @(posedge clk);
        cs <= 1'b1;
        waited = 0;
        while (byte_count < target && waited < byte_timeout)
        begin
            @(posedge clk);
            waited++;
        end
        if (byte_count < target)
        begin
            $display("Error: SPI frame timed out, byte_valid seen for %0d of %0d bytes",
                     full_bytes - (target - byte_count), full_bytes);
            error_count++;
        end
        model_frame(full_bytes);
        frame_q.delete();
        // cs idle between frames
        repeat (8) @(posedge clk);
    endtask

    task automatic check_reg(input reg_idx_t sel, input reg_val_t expected);
        @(posedge clk);
        readback_sel <= sel;
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (rb_data !== expected)
        begin
            $display("** Error: rb_data (sel %0d) = 0x%02h, expected 0x%02h",
                     sel, rb_data, expected);
            error_count++;
        end
    endtask

    task automatic check_bank();
        int s;
        for (s = 0; s < 8; s++)
            check_reg(reg_idx_t'(s), expected_rb(reg_idx_t'(s)));
    endtask

    // pwm must hold the expected value for a whole period
    task automatic check_pwm(input logic [3:0] expected);
        int n;
        logic reported;
        reported = 1'b0;
        for (n = 0; n < window; n++)
        begin
            @(negedge clk);
            if (pwm !== expected && !reported)
            begin
                $display("** Error: pwm = 0x%01h, expected 0x%01h", pwm, expected);
                error_count++;
                reported = 1'b1;
            end
        end
    endtask

    task automatic check_duty(input pwm_chan_e ch, input duty_t expected);
        int waited;
        int high;
        int n;
        logic prev;
        logic found;
        // a rising edge marks the counter wrap
        // duty 0 never rises and the wait stops after one period
        prev   = 1'b1;
        found  = 1'b0;
        waited = 0;
        while (!found && waited < window)
        begin
            @(negedge clk);
            if (pwm[ch] && !prev)
                found = 1'b1;
            prev = pwm[ch];
            waited++;
        end
        high = 0;
        for (n = 0; n < window; n++)
        begin
            if (pwm[ch])
                high++;
            @(negedge clk);
        end
        if (high != int'(expected) * `RGBW_PWM_PRESCALE)
        begin
            $display("** Error: pwm[%0d] high cycles = 0x%0h, expected 0x%0h (duty 0x%02h)",
                     ch, high, int'(expected) * `RGBW_PWM_PRESCALE, expected);
            error_count++;
        end
    endtask

    task automatic check_all_duties();
        int c;
        pwm_chan_e ch;
        for (c = 0; c < num_chans; c++)
        begin
            ch = pwm_chan_e'(c);
            check_duty(ch, duty_for(model_regs[chan_reg(ch)], model_regs[idx_intensity]));
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        int errs;
        errs = error_count - errs_before;
        tests_run++;
        if (errs == 0)
            $display("test %0d %s: ok", tests_run, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, errs);
        end
    endtask

    task automatic test_reset_state();
        int errs;
        errs = error_count;
        check_bank();
        check_pwm(4'h0);
        end_test("reset state", errs);
    endtask

    task automatic test_burst_write();
        int errs;
        int i;
        errs = error_count;
        frame_q.push_back(make_hdr(1'b1, idx_intensity));
        for (i = 0; i < `RGBW_NUM_REGS; i++)
            frame_q.push_back(rand_byte());
        send_frame(0);
        check_bank();
        end_test("burst write", errs);
    endtask

    task automatic test_mid_bank_overflow();
        int errs;
        int i;
        errs = error_count;
        // registers 4..6 written and the last two bytes run off the bank
        frame_q.push_back(make_hdr(1'b1, idx_color_idx));
        for (i = 0; i < 5; i++)
            frame_q.push_back(rand_byte());
        send_frame(0);
        check_bank();
        end_test("mid-bank write and overflow", errs);
    endtask

    task automatic test_read_only_abort();
        int errs;
        errs = error_count;
        // write flag clear so the data bytes are ignored
        frame_q.push_back(make_hdr(1'b0, idx_red));
        frame_q.push_back(rand_byte());
        frame_q.push_back(rand_byte());
        frame_q.push_back(rand_byte());
        send_frame(0);
        check_bank();
        // one full byte to green and then cs cut after 5 bits of the blue byte
        frame_q.push_back(make_hdr(1'b1, idx_green));
        frame_q.push_back(rand_byte());
        frame_q.push_back(~model_regs[idx_blue]);
        send_frame(5);
        check_bank();
        // next frame starts on a fresh bit count
        frame_q.push_back(make_hdr(1'b1, idx_blue));
        frame_q.push_back(~model_regs[idx_blue]);
        send_frame(0);
        check_bank();
        end_test("read-only frame and aborted byte", errs);
    endtask

    task automatic test_pwm_scaling();
        int errs;
        int round;
        errs = error_count;
        // random intensity first and then full intensity with blue dark
        for (round = 0; round < 2; round++)
        begin
            frame_q.push_back(make_hdr(1'b1, idx_intensity));
            frame_q.push_back((round == 0) ? rand_byte() : 8'hff);
            frame_q.push_back(rand_byte());
            frame_q.push_back(rand_byte());
            frame_q.push_back((round == 0) ? rand_byte() : 8'h00);
            frame_q.push_back(rand_byte());
            frame_q.push_back(rand_byte() | 8'h01);
            frame_q.push_back(rand_byte());
            send_frame(0);
            check_all_duties();
        end
        end_test("pwm scaling", errs);
    endtask

    task automatic test_disable();
        int errs;
        errs = error_count;
        frame_q.push_back(make_hdr(1'b1, idx_mode));
        frame_q.push_back(rand_byte() & 8'hfe);
        send_frame(0);
        check_pwm(4'h0);
        // bank is untouched by the disable
        check_bank();
        end_test("disable", errs);
    endtask

    initial
    begin
        int i;
        int total;
        void'($urandom(32'h4aa9_ca49));
        reset        <= 1'b1;
        sck          <= 1'b0;
        cs           <= 1'b1;
        mosi         <= 1'b0;
        readback_sel <= '0;
        for (i = 0; i < `RGBW_NUM_REGS; i++)
            model_regs[i] = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        test_reset_state();
        test_burst_write();
        test_mid_bank_overflow();
        test_read_only_abort();
        test_pwm_scaling();
        test_disable();

        total = error_count + int'(u_dut.u_sva.fail_count);
        $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, error_count, u_dut.u_sva.fail_count);
        if (total == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire
